// ==== src/dsz_consts.svh ====
// Bus widths, byte counts and AXI encodings for the write downsizer
`ifndef DSZ_CONSTS_SVH
`define DSZ_CONSTS_SVH

// Address and ID widths
`define DSZ_ADDR_W 32
`define DSZ_ID_W 4

// Slave (wide) and master (narrow) data widths
`define DSZ_SI_DATA_W 64
`define DSZ_MI_DATA_W 32
`define DSZ_SI_BYTES 8
`define DSZ_MI_BYTES 4

// AXI encodings
`define DSZ_MAX_LEN 255
`define DSZ_BURST_INCR 2'b01
`define DSZ_CACHE_MODIFIABLE 4'b0010

`endif

// ==== src/dsz_pkg.sv ====
// Channel payload structs and the burst descriptor type
`default_nettype none

`include "dsz_consts.svh"

package dsz_pkg;

  typedef logic [`DSZ_ID_W-1:0]   id_t;
  typedef logic [`DSZ_ADDR_W-1:0] addr_t;
  typedef logic [2:0]             size_t;

  // Write address channel
  typedef struct packed {
    id_t        id;
    addr_t      addr;
    logic [7:0] len;
    size_t      size;
    logic [1:0] burst;
    logic [3:0] cache;
    logic [2:0] prot;
  } aw_chan_t;

  // Wide write data beat on the slave side
  typedef struct packed {
    logic [`DSZ_SI_DATA_W-1:0] data;
    logic [`DSZ_SI_BYTES-1:0]  strb;
    logic                      last;
  } si_w_chan_t;

  // Narrow write data beat on the master side
  typedef struct packed {
    logic [`DSZ_MI_DATA_W-1:0] data;
    logic [`DSZ_MI_BYTES-1:0]  strb;
    logic                      last;
  } mi_w_chan_t;

  // Write response
  typedef struct packed {
    id_t        id;
    logic [1:0] resp;
  } b_chan_t;

  // Burst descriptor from decoder to serializer
  typedef struct packed {
    addr_t      addr;
    logic [8:0] count;      // narrow beats still to send
    size_t      orig_size;
    size_t      size;
    logic       downsize;
  } w_desc_t;

endpackage

`default_nettype wire

// ==== src/spill_reg.sv ====
// Two-slot valid/ready register for any packed payload type
`timescale 1ns/10ps
`default_nettype none

module spill_reg #(
  parameter type payload_t = logic
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     in_valid_i,
  output logic          in_ready_o,
  input  wire payload_t in_data_i,
  output logic          out_valid_o,
  input  wire logic     out_ready_i,
  output payload_t      out_data_o
);

  logic     a_full_q;
  logic     b_full_q;
  payload_t a_data_q;
  payload_t b_data_q;

  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  // Slot A takes new beats, slot B holds one when the output stalls
  assign a_fill  = in_valid_i && in_ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !out_ready_i;
  assign b_drain = b_full_q && out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) a_full_q <= a_fill;
      if (b_fill || b_drain) b_full_q <= b_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= in_data_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  assign in_ready_o  = !a_full_q || !b_full_q;
  assign out_valid_o = a_full_q || b_full_q;
  // Older beat sits in B whenever B is occupied
  assign out_data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

`default_nettype wire

// ==== src/burst_decoder.sv ====
// AW decoder FSM with narrow burst conversion and descriptor output
`timescale 1ns/10ps
`default_nettype none

`include "dsz_consts.svh"

module burst_decoder (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire dsz_pkg::aw_chan_t slv_aw_i,
  input  wire logic              slv_aw_valid_i,
  output logic                   slv_aw_ready_o,
  output dsz_pkg::aw_chan_t      aw_o,
  output logic                   aw_valid_o,
  input  wire logic              aw_ready_i,
  output dsz_pkg::w_desc_t       desc_o,
  output logic                   desc_start_o,
  input  wire logic              burst_done_i
);

  import dsz_pkg::*;

  localparam logic [2:0]  mi_size = 3'($clog2(`DSZ_MI_BYTES));
  localparam logic [31:0] mi_mask = 32'(`DSZ_MI_BYTES - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_BUSY
  } state_t;

  state_t   state_q;
  logic     desc_start_q;
  aw_chan_t aw_q;
  aw_chan_t aw_conv;
  w_desc_t  desc_q;
  w_desc_t  desc_conv;

  logic [31:0] size_mask;
  logic [15:0] ratio;
  logic [15:0] align_adj;
  logic [15:0] full_cnt;
  logic [7:0]  narrow_len;
  logic        downsize;

  // --------------------------------------------------------------------------
  // Conversion of the incoming request
  // --------------------------------------------------------------------------

  always_comb begin
    size_mask = (32'd1 << slv_aw_i.size) - 32'd1;
    ratio     = 16'((32'd1 << slv_aw_i.size) >> mi_size);
    // Narrow beats skipped before the start address inside the first word
    align_adj = 16'((slv_aw_i.addr & size_mask & ~mi_mask) >> mi_size);
    full_cnt  = (16'(slv_aw_i.len) + 16'd1) * ratio - align_adj;
    downsize  = (|(slv_aw_i.cache & `DSZ_CACHE_MODIFIABLE)) &&
                (slv_aw_i.burst == `DSZ_BURST_INCR) &&
                (slv_aw_i.size > mi_size);

    if ((full_cnt - 16'd1) > 16'(`DSZ_MAX_LEN)) begin
      narrow_len = 8'(`DSZ_MAX_LEN);
    end else begin
      narrow_len = 8'(full_cnt - 16'd1);
    end

    aw_conv = slv_aw_i;
    if (downsize) begin
      aw_conv.len  = narrow_len;
      aw_conv.size = mi_size;
    end

    desc_conv.addr      = slv_aw_i.addr;
    desc_conv.count     = 9'(aw_conv.len) + 9'd1;
    desc_conv.orig_size = slv_aw_i.size;
    desc_conv.size      = aw_conv.size;
    desc_conv.downsize  = downsize;
  end

  // --------------------------------------------------------------------------
  // Request FSM
  // --------------------------------------------------------------------------

  assign slv_aw_ready_o = (state_q == ST_IDLE);
  assign aw_valid_o     = (state_q == ST_ISSUE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= ST_IDLE;
      desc_start_q <= 1'b0;
    end else begin
      desc_start_q <= aw_valid_o && aw_ready_i;
      case (state_q)
        ST_IDLE:  if (slv_aw_valid_i) state_q <= ST_ISSUE;
        ST_ISSUE: if (aw_ready_i) state_q <= ST_BUSY;
        ST_BUSY:  if (burst_done_i) state_q <= ST_IDLE;
        default:  state_q <= ST_IDLE;
      endcase
    end
  end

  // Request capture
  always_ff @(posedge clk_i) begin
    if (slv_aw_valid_i && slv_aw_ready_o) begin
      aw_q   <= aw_conv;
      desc_q <= desc_conv;
    end
  end

  assign aw_o         = aw_q;
  assign desc_o       = desc_q;
  assign desc_start_o = desc_start_q;

endmodule

`default_nettype wire

// ==== src/lane_serializer.sv ====
// W beat serializer with slave-to-master byte lane steering
`timescale 1ns/10ps
`default_nettype none

`include "dsz_consts.svh"

module lane_serializer (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire dsz_pkg::w_desc_t    desc_i,
  input  wire logic                desc_start_i,
  input  wire dsz_pkg::si_w_chan_t slv_w_i,
  input  wire logic                slv_w_valid_i,
  output logic                     slv_w_ready_o,
  output dsz_pkg::mi_w_chan_t      w_o,
  output logic                     w_valid_o,
  input  wire logic                w_ready_i,
  output logic                     burst_done_o
);

  import dsz_pkg::*;

  logic    active_q;
  w_desc_t desc_q;

  logic [2:0]  si_off;
  logic [1:0]  mi_off;
  logic [7:0]  beat_bytes;
  logic [31:0] size_mask;
  logic [31:0] orig_mask;
  logic [31:0] next_addr;
  logic        last_beat;
  logic        word_done;
  logic        beat_fire;

  assign si_off     = desc_q.addr[2:0];
  assign mi_off     = desc_q.addr[1:0];
  assign beat_bytes = 8'd1 << desc_q.size;
  assign last_beat  = (desc_q.count == 9'd1);

  // --------------------------------------------------------------------------
  // Lane steering
  // --------------------------------------------------------------------------

  always_comb begin
    int lane;
    w_o      = '0;
    w_o.last = last_beat;
    for (int b = 0; b < `DSZ_SI_BYTES; b++) begin
      lane = b + int'(mi_off) - int'(si_off);
      // Only bytes of the current beat that land inside the master bus
      if ((b >= int'(si_off)) && ((b - int'(si_off)) < int'(beat_bytes)) &&
          (lane < `DSZ_MI_BYTES)) begin
        w_o.data[8*lane +: 8] = slv_w_i.data[8*b +: 8];
        w_o.strb[lane]        = slv_w_i.strb[b];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Address stepping and wide beat consumption
  // --------------------------------------------------------------------------

  assign size_mask = (32'd1 << desc_q.size) - 32'd1;
  assign orig_mask = (32'd1 << desc_q.orig_size) - 32'd1;
  assign next_addr = (desc_q.addr & ~size_mask) + (32'd1 << desc_q.size);
  assign word_done = (next_addr & ~orig_mask) != (desc_q.addr & ~orig_mask);

  assign w_valid_o    = active_q && slv_w_valid_i;
  assign beat_fire    = w_valid_o && w_ready_i;
  assign burst_done_o = beat_fire && last_beat;

  // Passthrough consumes every beat, downsize only at the end of a word
  assign slv_w_ready_o = beat_fire && (!desc_q.downsize || word_done || last_beat);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      desc_q   <= '0;
    end else if (desc_start_i) begin
      active_q <= 1'b1;
      desc_q   <= desc_i;
    end else if (beat_fire) begin
      desc_q.addr  <= next_addr;
      desc_q.count <= desc_q.count - 9'd1;
      if (last_beat) begin
        active_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/axi_write_downsizer.sv ====
// Top level of the AXI write downsizer with B channel passthrough
`timescale 1ns/10ps
`default_nettype none

module axi_write_downsizer (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  // Slave port, 64-bit data
  input  wire dsz_pkg::aw_chan_t   slv_aw_i,
  input  wire logic                slv_aw_valid_i,
  output logic                     slv_aw_ready_o,
  input  wire dsz_pkg::si_w_chan_t slv_w_i,
  input  wire logic                slv_w_valid_i,
  output logic                     slv_w_ready_o,
  output dsz_pkg::b_chan_t         slv_b_o,
  output logic                     slv_b_valid_o,
  input  wire logic                slv_b_ready_i,
  // Master port, 32-bit data
  output dsz_pkg::aw_chan_t        mst_aw_o,
  output logic                     mst_aw_valid_o,
  input  wire logic                mst_aw_ready_i,
  output dsz_pkg::mi_w_chan_t      mst_w_o,
  output logic                     mst_w_valid_o,
  input  wire logic                mst_w_ready_i,
  input  wire dsz_pkg::b_chan_t    mst_b_i,
  input  wire logic                mst_b_valid_i,
  output logic                     mst_b_ready_o
);

  import dsz_pkg::*;

  aw_chan_t   dec_aw;
  logic       dec_aw_valid;
  logic       dec_aw_ready;
  w_desc_t    desc;
  logic       desc_start;
  logic       burst_done;
  mi_w_chan_t ser_w;
  logic       ser_w_valid;
  logic       ser_w_ready;

  // --------------------------------------------------------------------------
  // Write address path
  // --------------------------------------------------------------------------

  burst_decoder i_decoder (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_i       (slv_aw_i),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .aw_o           (dec_aw),
    .aw_valid_o     (dec_aw_valid),
    .aw_ready_i     (dec_aw_ready),
    .desc_o         (desc),
    .desc_start_o   (desc_start),
    .burst_done_i   (burst_done)
  );

  spill_reg #(.payload_t(aw_chan_t)) i_aw_spill (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (dec_aw_valid),
    .in_ready_o  (dec_aw_ready),
    .in_data_i   (dec_aw),
    .out_valid_o (mst_aw_valid_o),
    .out_ready_i (mst_aw_ready_i),
    .out_data_o  (mst_aw_o)
  );

  // --------------------------------------------------------------------------
  // Write data path
  // --------------------------------------------------------------------------

  lane_serializer i_serializer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .desc_i        (desc),
    .desc_start_i  (desc_start),
    .slv_w_i       (slv_w_i),
    .slv_w_valid_i (slv_w_valid_i),
    .slv_w_ready_o (slv_w_ready_o),
    .w_o           (ser_w),
    .w_valid_o     (ser_w_valid),
    .w_ready_i     (ser_w_ready),
    .burst_done_o  (burst_done)
  );

  spill_reg #(.payload_t(mi_w_chan_t)) i_w_spill (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (ser_w_valid),
    .in_ready_o  (ser_w_ready),
    .in_data_i   (ser_w),
    .out_valid_o (mst_w_valid_o),
    .out_ready_i (mst_w_ready_i),
    .out_data_o  (mst_w_o)
  );

  // Write response needs no conversion
  assign slv_b_o       = mst_b_i;
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;

endmodule

`default_nettype wire

// ==== tb/tb_axi_write_downsizer.sv ====
// Testbench for the AXI write downsizer: random bursts, reference model, checks, watchdog
`timescale 1ns/10ps
`default_nettype none

`include "dsz_consts.svh"

module tb_axi_write_downsizer;

  import dsz_pkg::*;

  localparam int num_bursts       = 200;
  localparam int cycles_per_burst = 300;

  logic        clk = 1'b0;
  logic        rst_n;
  aw_chan_t    slv_aw;
  logic        slv_aw_valid;
  logic        slv_aw_ready;
  si_w_chan_t  slv_w;
  logic        slv_w_valid;
  logic        slv_w_ready;
  b_chan_t     slv_b;
  logic        slv_b_valid;
  logic        slv_b_ready;
  aw_chan_t    mst_aw;
  logic        mst_aw_valid;
  logic        mst_aw_ready;
  mi_w_chan_t  mst_w;
  logic        mst_w_valid;
  logic        mst_w_ready;
  b_chan_t     mst_b;
  logic        mst_b_valid;
  logic        mst_b_ready;

  logic [31:0] lfsr_q = 32'h4d0b_9d3d;
  logic [63:0] wide_data [256];
  logic [7:0]  wide_strb [256];
  aw_chan_t    exp_aw_q [$];
  mi_w_chan_t  exp_w_q [$];
  aw_chan_t    aw_exp;
  mi_w_chan_t  w_exp;
  int          aw_errs = 0;
  int          w_errs = 0;
  int          b_errs = 0;
  int          seq_errs = 0;
  int          reset_errs = 0;

  always #4 clk = ~clk;

  axi_write_downsizer dut_i (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .slv_aw_i       (slv_aw),
    .slv_aw_valid_i (slv_aw_valid),
    .slv_aw_ready_o (slv_aw_ready),
    .slv_w_i        (slv_w),
    .slv_w_valid_i  (slv_w_valid),
    .slv_w_ready_o  (slv_w_ready),
    .slv_b_o        (slv_b),
    .slv_b_valid_o  (slv_b_valid),
    .slv_b_ready_i  (slv_b_ready),
    .mst_aw_o       (mst_aw),
    .mst_aw_valid_o (mst_aw_valid),
    .mst_aw_ready_i (mst_aw_ready),
    .mst_w_o        (mst_w),
    .mst_w_valid_o  (mst_w_valid),
    .mst_w_ready_i  (mst_w_ready),
    .mst_b_i        (mst_b),
    .mst_b_valid_i  (mst_b_valid),
    .mst_b_ready_o  (mst_b_ready)
  );

  // Galois LFSR, one step for every bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hB4BC_D35C) : (lfsr_q >> 1);
      val    = {val[30:0], lfsr_q[0]};
    end
    return val;
  endfunction

  // --------------------------------------------------------------------------
  // Reference model of the narrow AW and the narrow beat sequence
  // --------------------------------------------------------------------------

  task automatic predict_burst(input aw_chan_t aw);
    aw_chan_t    nar;
    mi_w_chan_t  beat;
    logic        down;
    int          count;
    int          adj;
    int          wide;
    int          nbytes;
    int          mi_lane;
    int          si_lane;
    logic [31:0] addr;
    logic [31:0] next;
    down  = ((aw.cache & `DSZ_CACHE_MODIFIABLE) != 4'd0) &&
            (aw.burst == `DSZ_BURST_INCR) && (aw.size > 3'd2);
    nar   = aw;
    count = int'(aw.len) + 1;
    if (down) begin
      // Words of 4 bytes skipped ahead of the start address
      adj      = int'(aw.addr & ((32'd1 << aw.size) - 32'd1)) / 4;
      count    = count * ((1 << aw.size) / 4) - adj;
      nar.len  = 8'(count - 1);
      nar.size = 3'd2;
    end
    exp_aw_q.push_back(nar);
    addr   = aw.addr;
    wide   = 0;
    nbytes = 1 << nar.size;
    for (int i = 0; i < count; i++) begin
      beat      = '0;
      beat.last = (i == count - 1);
      for (int k = 0; k < nbytes; k++) begin
        mi_lane = int'(addr[1:0]) + k;
        si_lane = int'(addr[2:0]) + k;
        if ((mi_lane < 4) && (si_lane < 8)) begin
          beat.data[8*mi_lane +: 8] = wide_data[wide][8*si_lane +: 8];
          beat.strb[mi_lane]        = wide_strb[wide][si_lane];
        end
      end
      exp_w_q.push_back(beat);
      next = ((addr >> nar.size) << nar.size) + 32'(nbytes);
      if (!down || beat.last || ((next >> aw.size) != (addr >> aw.size))) begin
        wide++;
      end
      addr = next;
    end
  endtask

  // --------------------------------------------------------------------------
  // Slave side stimulus
  // --------------------------------------------------------------------------

  task automatic send_burst();
    aw_chan_t aw;
    int       nwide;
    aw.id    = 4'(rand_bits(4));
    aw.addr  = rand_bits(32);
    aw.size  = 3'(rand_bits(2));
    aw.burst = 2'(rand_bits(2));
    aw.cache = 4'(rand_bits(4));
    aw.prot  = 3'(rand_bits(3));
    aw.len   = 8'(rand_bits(8));
    if (aw.burst == 2'b11) aw.burst = `DSZ_BURST_INCR;
    if (rand_bits(2) == 32'd0) aw.addr[2:0] = 3'b000;
    // Size 8 doubles the narrow beat count
    if (aw.size == 3'd3) aw.len[7] = 1'b0;
    nwide = int'(aw.len) + 1;
    for (int w = 0; w < nwide; w++) begin
      wide_data[w] = {rand_bits(32), rand_bits(32)};
      wide_strb[w] = 8'(rand_bits(8));
    end
    predict_burst(aw);

    slv_aw       = aw;
    slv_aw_valid = 1'b1;
    do @(posedge clk); while (!slv_aw_ready);
    @(negedge clk);
    slv_aw_valid = 1'b0;

    for (int w = 0; w < nwide; w++) begin
      if (rand_bits(3) == 32'd0) begin
        slv_w_valid = 1'b0;
        @(negedge clk);
      end
      slv_w.data  = wide_data[w];
      slv_w.strb  = wide_strb[w];
      slv_w.last  = (w == nwide - 1);
      slv_w_valid = 1'b1;
      do @(posedge clk); while (!slv_w_ready);
      @(negedge clk);
    end
    slv_w_valid = 1'b0;
    // Drain the master side before the next request
    while ((exp_w_q.size() != 0) || (exp_aw_q.size() != 0)) @(negedge clk);
  endtask

  // Master side readiness and B responses
  initial begin
    mst_aw_ready = 1'b0;
    mst_w_ready  = 1'b0;
    mst_b        = '0;
    mst_b_valid  = 1'b0;
    slv_b_ready  = 1'b0;
    forever begin
      @(negedge clk);
      mst_aw_ready = (rand_bits(1) != 32'd0);
      mst_w_ready  = (rand_bits(2) != 32'd0);
      mst_b.id     = 4'(rand_bits(4));
      mst_b.resp   = 2'(rand_bits(2));
      mst_b_valid  = (rand_bits(1) != 32'd0);
      slv_b_ready  = (rand_bits(1) != 32'd0);
    end
  end

  // --------------------------------------------------------------------------
  // Master side checks
  // --------------------------------------------------------------------------

  always @(posedge clk) begin
    if (rst_n && mst_aw_valid && mst_aw_ready) begin
      assert (exp_aw_q.size() != 0) else begin
        seq_errs++;
        $display("A write address appeared on the master port with no burst pending");
      end
      if (exp_aw_q.size() != 0) begin
        aw_exp = exp_aw_q.pop_front();
        assert (mst_aw == aw_exp) else begin
          aw_errs++;
          $display("FAIL %0t: mst_aw is %h, expected %h", $time, mst_aw, aw_exp);
        end
      end
    end
    if (rst_n && mst_w_valid && mst_w_ready) begin
      assert (exp_w_q.size() != 0) else begin
        seq_errs++;
        $display("A write data beat appeared on the master port with none expected");
      end
      if (exp_w_q.size() != 0) begin
        w_exp = exp_w_q.pop_front();
        assert (mst_w == w_exp) else begin
          w_errs++;
          $display("FAIL %0t: mst_w data %h strb %b last %b, expected %h %b %b",
                   $time, mst_w.data, mst_w.strb, mst_w.last,
                   w_exp.data, w_exp.strb, w_exp.last);
        end
      end
    end
    assert ((slv_b == mst_b) && (slv_b_valid == mst_b_valid) &&
            (mst_b_ready == slv_b_ready)) else begin
      b_errs++;
      $display("FAIL %0t: B channel not passed through, slv_b %h valid %b ready %b",
               $time, slv_b, slv_b_valid, mst_b_ready);
    end
  end

  // --------------------------------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------------------------------

  initial begin
    int total;
    rst_n        = 1'b0;
    slv_aw       = '0;
    slv_aw_valid = 1'b0;
    slv_w        = '0;
    slv_w_valid  = 1'b0;
    repeat (5) @(negedge clk);
    assert (!mst_aw_valid && !mst_w_valid && !slv_w_ready && slv_aw_ready) else begin
      reset_errs++;
      $display("FAIL %0t: channel valid or ready signals wrong after reset", $time);
    end
    rst_n = 1'b1;
    @(negedge clk);
    for (int n = 0; n < num_bursts; n++) begin
      send_burst();
    end
    repeat (4) @(negedge clk);
    total = aw_errs + w_errs + b_errs + seq_errs + reset_errs;
    $display("Errors: aw %0d, w %0d, b %0d, sequence %0d, reset %0d",
             aw_errs, w_errs, b_errs, seq_errs, reset_errs);
    if (total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    repeat (num_bursts * cycles_per_burst) @(posedge clk);
    $display("Timeout: the bursts did not complete within %0d cycles",
             num_bursts * cycles_per_burst);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+src
src/dsz_pkg.sv
src/spill_reg.sv
src/burst_decoder.sv
src/lane_serializer.sv
src/axi_write_downsizer.sv
tb/tb_axi_write_downsizer.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then scan the simulation log for the fail message
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
  -f src.f --top-module tb_axi_write_downsizer -o tb_sim > build.log 2>&1 &&
  ./obj_dir/tb_sim > sim.log 2>&1 ||
  { echo "Build or simulation run did not complete, see build.log and sim.log"; exit 1; }
grep -qF "*** TEST FAILED ***" sim.log &&
  { echo "Simulation reported failure, see sim.log"; exit 1; } ||
  { echo "Simulation finished without failure"; exit 0; }
